// File: issue_pkg.sv
// Shared types of the issue stage
// Physical register tags, dispatch ages, opcodes and the age comparison

`default_nettype none

package issue_pkg;

  // ========================================
  // Widths and types
  // ========================================

  // 64 physical registers
  localparam int PREG_W = 6;
  typedef logic [PREG_W-1:0] preg_t;

  // Top bit is the wrap bit, lower bits the sequence index
  localparam int AGE_W = 5;
  typedef logic [AGE_W-1:0] age_t;

  // Carried through, never decoded
  localparam int OP_W = 4;
  typedef logic [OP_W-1:0] opcode_t;

  // ========================================
  // Age comparison
  // ========================================

  // True when age a was dispatched before age b
  function automatic logic age_older(input age_t a, input age_t b);
    if (a[AGE_W-1] == b[AGE_W-1]) begin
      return a[AGE_W-2:0] < b[AGE_W-2:0];
    end else begin
      // Index wrapped between the two ops
      return a[AGE_W-2:0] > b[AGE_W-2:0];
    end
  endfunction

endpackage

`default_nettype wire

// File: dispatch_steer.sv
// Dispatch steering
// Gives each accepted op an age, marks sources against the busy table
// and sends the op to a bank with room, round-robin

`default_nettype none

module dispatch_steer import issue_pkg::*; #(
  parameter int NUM_BANKS = 2
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 flush_i,
  // Dispatch port
  input  wire logic                 disp_valid_i,
  input  wire opcode_t              disp_op_i,
  input  wire preg_t                disp_psrc0_i,
  input  wire logic                 disp_psrc0_valid_i,
  input  wire preg_t                disp_psrc1_i,
  input  wire logic                 disp_psrc1_valid_i,
  input  wire preg_t                disp_pdest_i,
  input  wire logic                 disp_pdest_valid_i,
  output logic                      disp_ready_o,
  // Wakeup broadcast
  input  wire logic                 wk_valid_i,
  input  wire preg_t                wk_tag_i,
  // Bank write port
  input  wire logic [NUM_BANKS-1:0] wr_ready_i,
  output logic [NUM_BANKS-1:0]      wr_valid_o,
  output opcode_t                   wr_op_o,
  output age_t                      wr_age_o,
  output preg_t                     wr_psrc0_o,
  output logic                      wr_psrc0_wait_o,
  output preg_t                     wr_psrc1_o,
  output logic                      wr_psrc1_wait_o,
  output preg_t                     wr_pdest_o,
  output logic                      wr_pdest_valid_o
);

  localparam int BW = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

  logic [2**PREG_W-1:0] busy_q;
  age_t                 age_q;
  logic [BW-1:0]        last_q;
  logic [BW-1:0]        sel_idx;
  logic                 sel_found;
  logic                 accept;

  // ========================================
  // Round-robin bank select
  // ========================================

  // Search starts at the bank after the one used last
  always_comb begin
    int cand;
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int i = 1; i <= NUM_BANKS; i++) begin
      cand = (int'(last_q) + i) % NUM_BANKS;
      if (!sel_found && wr_ready_i[cand]) begin
        sel_found = 1'b1;
        sel_idx   = BW'(cand);
      end
    end
  end

  assign disp_ready_o = sel_found;
  assign accept       = disp_valid_i && sel_found;

  always_comb begin
    wr_valid_o = '0;
    if (accept) begin
      wr_valid_o[sel_idx] = 1'b1;
    end
  end

  // ========================================
  // Payload and source readiness
  // ========================================

  assign wr_op_o          = disp_op_i;
  assign wr_age_o         = age_q;
  assign wr_psrc0_o       = disp_psrc0_i;
  assign wr_psrc1_o       = disp_psrc1_i;
  assign wr_pdest_o       = disp_pdest_i;
  assign wr_pdest_valid_o = disp_pdest_valid_i;

  // A wakeup in the same cycle counts as ready
  assign wr_psrc0_wait_o = disp_psrc0_valid_i && busy_q[disp_psrc0_i] &&
                           !(wk_valid_i && (wk_tag_i == disp_psrc0_i));
  assign wr_psrc1_wait_o = disp_psrc1_valid_i && busy_q[disp_psrc1_i] &&
                           !(wk_valid_i && (wk_tag_i == disp_psrc1_i));

  // ========================================
  // Busy table, age counter, last bank
  // ========================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= '0;
      age_q  <= '0;
      last_q <= BW'(NUM_BANKS - 1);
    end else if (flush_i) begin
      busy_q <= '0;
      age_q  <= '0;
      last_q <= BW'(NUM_BANKS - 1);
    end else begin
      if (wk_valid_i) begin
        busy_q[wk_tag_i] <= 1'b0;
      end
      // New producer wins over a wakeup of the same tag
      if (accept) begin
        if (disp_pdest_valid_i) begin
          busy_q[disp_pdest_i] <= 1'b1;
        end
        age_q  <= age_t'(age_q + 1'b1);
        last_q <= sel_idx;
      end
    end
  end

  // Only a register with a producer in flight can be woken
  a_wk_tag_busy: assert property (
    @(posedge clk) disable iff (!rst_n || flush_i)
    wk_valid_i |-> busy_q[wk_tag_i]
  );

endmodule

`default_nettype wire

// File: rs_bank.sv
// Reservation-station bank
// Holds ops until both sources are ready and offers the oldest ready one

`default_nettype none

module rs_bank import issue_pkg::*; #(
  parameter int BANK_DEPTH = 4
) (
  input  wire logic    clk,
  input  wire logic    rst_n,
  input  wire logic    flush_i,
  // Write port
  input  wire logic    wr_valid_i,
  input  wire opcode_t wr_op_i,
  input  wire age_t    wr_age_i,
  input  wire preg_t   wr_psrc0_i,
  input  wire logic    wr_psrc0_wait_i,
  input  wire preg_t   wr_psrc1_i,
  input  wire logic    wr_psrc1_wait_i,
  input  wire preg_t   wr_pdest_i,
  input  wire logic    wr_pdest_valid_i,
  output logic         wr_ready_o,
  // Wakeup broadcast
  input  wire logic    wk_valid_i,
  input  wire preg_t   wk_tag_i,
  // Issue port
  input  wire logic    iss_ready_i,
  output logic         iss_valid_o,
  output opcode_t      iss_op_o,
  output age_t         iss_age_o,
  output preg_t        iss_pdest_o,
  output logic         iss_pdest_valid_o
);

  localparam int IW = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

  // Entry storage
  logic [BANK_DEPTH-1:0] vld_q;
  opcode_t               op_q       [BANK_DEPTH];
  age_t                  age_q      [BANK_DEPTH];
  preg_t                 psrc0_q    [BANK_DEPTH];
  preg_t                 psrc1_q    [BANK_DEPTH];
  logic                  w0_q       [BANK_DEPTH];
  logic                  w1_q       [BANK_DEPTH];
  preg_t                 pdest_q    [BANK_DEPTH];
  logic                  pdest_v_q  [BANK_DEPTH];

  logic [BANK_DEPTH-1:0] rdy;
  logic [IW-1:0]         wr_idx;
  logic [IW-1:0]         sel_idx;
  logic                  sel_found;
  logic                  iss_fire;

  // ========================================
  // Write slot
  // ========================================

  assign wr_ready_o = !(&vld_q);

  // Lowest free entry
  always_comb begin
    wr_idx = '0;
    for (int i = BANK_DEPTH - 1; i >= 0; i--) begin
      if (!vld_q[i]) begin
        wr_idx = IW'(i);
      end
    end
  end

  // ========================================
  // Oldest-ready select
  // ========================================

  always_comb begin
    for (int i = 0; i < BANK_DEPTH; i++) begin
      rdy[i] = vld_q[i] && !w0_q[i] && !w1_q[i];
    end
  end

  always_comb begin
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int i = 0; i < BANK_DEPTH; i++) begin
      if (rdy[i] && (!sel_found || age_older(age_q[i], age_q[sel_idx]))) begin
        sel_found = 1'b1;
        sel_idx   = IW'(i);
      end
    end
  end

  assign iss_valid_o       = sel_found;
  assign iss_op_o          = op_q[sel_idx];
  assign iss_age_o         = age_q[sel_idx];
  assign iss_pdest_o       = pdest_q[sel_idx];
  assign iss_pdest_valid_o = pdest_v_q[sel_idx];
  assign iss_fire          = sel_found && iss_ready_i;

  // ========================================
  // Entry state
  // ========================================

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else if (flush_i) begin
      vld_q <= '0;
    end else begin
      if (iss_fire) begin
        vld_q[sel_idx] <= 1'b0;
      end
      // Write slot is always a free entry, never the one issuing
      if (wr_valid_i) begin
        vld_q[wr_idx] <= 1'b1;
      end
    end
  end

  // Payload and wait bits, qualified by the valid bit
  always_ff @(posedge clk) begin
    for (int i = 0; i < BANK_DEPTH; i++) begin
      if (wk_valid_i && (psrc0_q[i] == wk_tag_i)) begin
        w0_q[i] <= 1'b0;
      end
      if (wk_valid_i && (psrc1_q[i] == wk_tag_i)) begin
        w1_q[i] <= 1'b0;
      end
    end
    if (wr_valid_i) begin
      op_q[wr_idx]      <= wr_op_i;
      age_q[wr_idx]     <= wr_age_i;
      psrc0_q[wr_idx]   <= wr_psrc0_i;
      psrc1_q[wr_idx]   <= wr_psrc1_i;
      w0_q[wr_idx]      <= wr_psrc0_wait_i;
      w1_q[wr_idx]      <= wr_psrc1_wait_i;
      pdest_q[wr_idx]   <= wr_pdest_i;
      pdest_v_q[wr_idx] <= wr_pdest_valid_i;
    end
  end

  // Steering only writes into a bank that has room
  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (!rst_n || flush_i)
    wr_valid_i |-> wr_ready_o
  );

endmodule

`default_nettype wire

// File: exec_pipe.sv
// Execution pipe
// Takes the oldest offer across the banks, runs it through a stallable
// fixed-latency pipe and drives completion and the wakeup broadcast

`default_nettype none

module exec_pipe import issue_pkg::*; #(
  parameter int NUM_BANKS = 2,
  parameter int EXEC_LAT  = 2
) (
  input  wire logic                    clk,
  input  wire logic                    rst_n,
  input  wire logic                    flush_i,
  // Issue offers, one per bank
  input  wire logic [NUM_BANKS-1:0]    iss_valid_i,
  input  wire opcode_t [NUM_BANKS-1:0] iss_op_i,
  input  wire age_t [NUM_BANKS-1:0]    iss_age_i,
  input  wire preg_t [NUM_BANKS-1:0]   iss_pdest_i,
  input  wire logic [NUM_BANKS-1:0]    iss_pdest_valid_i,
  output logic [NUM_BANKS-1:0]         iss_ready_o,
  // Completion port
  input  wire logic                    cmp_ready_i,
  output logic                         cmp_valid_o,
  output opcode_t                      cmp_op_o,
  output age_t                         cmp_age_o,
  output preg_t                        cmp_pdest_o,
  output logic                         cmp_pdest_valid_o,
  // Wakeup broadcast
  output logic                         wk_valid_o,
  output preg_t                        wk_tag_o
);

  localparam int BW = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

  logic [EXEC_LAT-1:0] st_vld_q;
  opcode_t             st_op_q     [EXEC_LAT];
  age_t                st_age_q    [EXEC_LAT];
  preg_t               st_pdest_q  [EXEC_LAT];
  logic                st_pdv_q    [EXEC_LAT];

  // Stage inputs
  logic [EXEC_LAT-1:0] in_vld;
  opcode_t             in_op       [EXEC_LAT];
  age_t                in_age      [EXEC_LAT];
  preg_t               in_pdest    [EXEC_LAT];
  logic                in_pdv      [EXEC_LAT];

  logic [EXEC_LAT-1:0] can_load;
  logic [BW-1:0]       pick_idx;
  logic                pick_found;
  logic                iss_fire;

  // ========================================
  // Oldest-first arbiter
  // ========================================

  always_comb begin
    pick_found = 1'b0;
    pick_idx   = '0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (iss_valid_i[b] &&
          (!pick_found || age_older(iss_age_i[b], iss_age_i[pick_idx]))) begin
        pick_found = 1'b1;
        pick_idx   = BW'(b);
      end
    end
  end

  assign iss_fire = pick_found && can_load[0];

  always_comb begin
    iss_ready_o = '0;
    if (iss_fire) begin
      iss_ready_o[pick_idx] = 1'b1;
    end
  end

  // ========================================
  // Pipe stages
  // ========================================

  // A stage loads when empty or when its op moves on
  always_comb begin
    can_load[EXEC_LAT-1] = !st_vld_q[EXEC_LAT-1] || cmp_ready_i;
    for (int k = EXEC_LAT - 2; k >= 0; k--) begin
      can_load[k] = !st_vld_q[k] || can_load[k+1];
    end
  end

  always_comb begin
    in_vld[0]   = iss_fire;
    in_op[0]    = iss_op_i[pick_idx];
    in_age[0]   = iss_age_i[pick_idx];
    in_pdest[0] = iss_pdest_i[pick_idx];
    in_pdv[0]   = iss_pdest_valid_i[pick_idx];
    for (int k = 1; k < EXEC_LAT; k++) begin
      in_vld[k]   = st_vld_q[k-1];
      in_op[k]    = st_op_q[k-1];
      in_age[k]   = st_age_q[k-1];
      in_pdest[k] = st_pdest_q[k-1];
      in_pdv[k]   = st_pdv_q[k-1];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      st_vld_q <= '0;
    end else if (flush_i) begin
      st_vld_q <= '0;
    end else begin
      for (int k = 0; k < EXEC_LAT; k++) begin
        if (can_load[k]) begin
          st_vld_q[k] <= in_vld[k];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int k = 0; k < EXEC_LAT; k++) begin
      if (can_load[k] && in_vld[k]) begin
        st_op_q[k]    <= in_op[k];
        st_age_q[k]   <= in_age[k];
        st_pdest_q[k] <= in_pdest[k];
        st_pdv_q[k]   <= in_pdv[k];
      end
    end
  end

  // ========================================
  // Completion and wakeup
  // ========================================

  assign cmp_valid_o       = st_vld_q[EXEC_LAT-1];
  assign cmp_op_o          = st_op_q[EXEC_LAT-1];
  assign cmp_age_o         = st_age_q[EXEC_LAT-1];
  assign cmp_pdest_o       = st_pdest_q[EXEC_LAT-1];
  assign cmp_pdest_valid_o = st_pdv_q[EXEC_LAT-1];

  assign wk_valid_o = cmp_valid_o && cmp_ready_i && cmp_pdest_valid_o;
  assign wk_tag_o   = cmp_pdest_o;

  a_one_grant: assert property (
    @(posedge clk) disable iff (!rst_n || flush_i)
    $onehot0(iss_ready_o)
  );

  // Completion holds steady until it is taken
  a_cmp_stable: assert property (
    @(posedge clk) disable iff (!rst_n || flush_i)
    cmp_valid_o && !cmp_ready_i |=> cmp_valid_o &&
      $stable({cmp_op_o, cmp_age_o, cmp_pdest_o, cmp_pdest_valid_o})
  );

endmodule

`default_nettype wire

// File: ooo_issue_top.sv
// Issue stage top level
// Steering block, a row of reservation-station banks and the execution pipe

`default_nettype none

module ooo_issue_top import issue_pkg::*; #(
  parameter int NUM_BANKS  = 2,
  parameter int BANK_DEPTH = 4,
  parameter int EXEC_LAT   = 2
) (
  input  wire logic    clk,
  input  wire logic    rst_n,
  input  wire logic    flush_i,
  // Dispatch port
  input  wire logic    disp_valid_i,
  input  wire opcode_t disp_op_i,
  input  wire preg_t   disp_psrc0_i,
  input  wire logic    disp_psrc0_valid_i,
  input  wire preg_t   disp_psrc1_i,
  input  wire logic    disp_psrc1_valid_i,
  input  wire preg_t   disp_pdest_i,
  input  wire logic    disp_pdest_valid_i,
  output logic         disp_ready_o,
  // Completion port
  input  wire logic    cmp_ready_i,
  output logic         cmp_valid_o,
  output opcode_t      cmp_op_o,
  output age_t         cmp_age_o,
  output preg_t        cmp_pdest_o,
  output logic         cmp_pdest_valid_o
);

  // Bank write port
  logic [NUM_BANKS-1:0] wr_valid;
  logic [NUM_BANKS-1:0] wr_ready;
  opcode_t              wr_op;
  age_t                 wr_age;
  preg_t                wr_psrc0;
  logic                 wr_psrc0_wait;
  preg_t                wr_psrc1;
  logic                 wr_psrc1_wait;
  preg_t                wr_pdest;
  logic                 wr_pdest_valid;

  // Issue port
  logic [NUM_BANKS-1:0]    iss_valid;
  logic [NUM_BANKS-1:0]    iss_ready;
  opcode_t [NUM_BANKS-1:0] iss_op;
  age_t [NUM_BANKS-1:0]    iss_age;
  preg_t [NUM_BANKS-1:0]   iss_pdest;
  logic [NUM_BANKS-1:0]    iss_pdest_valid;

  // Wakeup broadcast
  logic  wk_valid;
  preg_t wk_tag;

  dispatch_steer #(
    .NUM_BANKS (NUM_BANKS)
  ) u_steer (
    .clk, .rst_n, .flush_i,
    .disp_valid_i, .disp_op_i,
    .disp_psrc0_i, .disp_psrc0_valid_i,
    .disp_psrc1_i, .disp_psrc1_valid_i,
    .disp_pdest_i, .disp_pdest_valid_i,
    .disp_ready_o,
    .wk_valid_i       (wk_valid),
    .wk_tag_i         (wk_tag),
    .wr_ready_i       (wr_ready),
    .wr_valid_o       (wr_valid),
    .wr_op_o          (wr_op),
    .wr_age_o         (wr_age),
    .wr_psrc0_o       (wr_psrc0),
    .wr_psrc0_wait_o  (wr_psrc0_wait),
    .wr_psrc1_o       (wr_psrc1),
    .wr_psrc1_wait_o  (wr_psrc1_wait),
    .wr_pdest_o       (wr_pdest),
    .wr_pdest_valid_o (wr_pdest_valid)
  );

  // Write payload goes to every bank, wr_valid picks one
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    rs_bank #(
      .BANK_DEPTH (BANK_DEPTH)
    ) u_bank (
      .clk, .rst_n, .flush_i,
      .wr_valid_i        (wr_valid[b]),
      .wr_op_i           (wr_op),
      .wr_age_i          (wr_age),
      .wr_psrc0_i        (wr_psrc0),
      .wr_psrc0_wait_i   (wr_psrc0_wait),
      .wr_psrc1_i        (wr_psrc1),
      .wr_psrc1_wait_i   (wr_psrc1_wait),
      .wr_pdest_i        (wr_pdest),
      .wr_pdest_valid_i  (wr_pdest_valid),
      .wr_ready_o        (wr_ready[b]),
      .wk_valid_i        (wk_valid),
      .wk_tag_i          (wk_tag),
      .iss_ready_i       (iss_ready[b]),
      .iss_valid_o       (iss_valid[b]),
      .iss_op_o          (iss_op[b]),
      .iss_age_o         (iss_age[b]),
      .iss_pdest_o       (iss_pdest[b]),
      .iss_pdest_valid_o (iss_pdest_valid[b])
    );
  end

  exec_pipe #(
    .NUM_BANKS (NUM_BANKS),
    .EXEC_LAT  (EXEC_LAT)
  ) u_pipe (
    .clk, .rst_n, .flush_i,
    .iss_valid_i       (iss_valid),
    .iss_op_i          (iss_op),
    .iss_age_i         (iss_age),
    .iss_pdest_i       (iss_pdest),
    .iss_pdest_valid_i (iss_pdest_valid),
    .iss_ready_o       (iss_ready),
    .cmp_ready_i, .cmp_valid_o, .cmp_op_o, .cmp_age_o,
    .cmp_pdest_o, .cmp_pdest_valid_o,
    .wk_valid_o        (wk_valid),
    .wk_tag_o          (wk_tag)
  );

endmodule

`default_nettype wire

// File: tb_ooo_issue.sv
// Testbench for the issue stage
// Drives dispatch and completion, keeps a reference model of the ops
// in flight and checks completions, ordering, stalls, capacity and flush

`default_nettype none

module tb_ooo_issue import issue_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_BANKS       = 2;
  localparam int BANK_DEPTH      = 4;
  localparam int EXEC_LAT        = 2;
  localparam int CAP             = NUM_BANKS * BANK_DEPTH + EXEC_LAT;
  localparam int N_IND           = 20;
  localparam int N_CHAIN         = 12;
  localparam int N_RAND          = 40;
  localparam int N_BP            = 8;
  localparam int N_FL            = 4;
  localparam int TOTAL_OPS       = N_IND + N_CHAIN + N_RAND + N_BP + CAP + 2 * N_FL;
  localparam int WATCHDOG_CYCLES = TOTAL_OPS * (EXEC_LAT + 20) + 200;
  localparam int MAX_SER         = TOTAL_OPS + 16;
  localparam int DISP_WAIT       = 100;
  localparam int DRAIN_LIMIT     = 300;

  logic    clk;
  logic    rst_n;
  logic    flush_i;
  logic    disp_valid_i;
  opcode_t disp_op_i;
  preg_t   disp_psrc0_i;
  logic    disp_psrc0_valid_i;
  preg_t   disp_psrc1_i;
  logic    disp_psrc1_valid_i;
  preg_t   disp_pdest_i;
  logic    disp_pdest_valid_i;
  logic    disp_ready_o;
  logic    cmp_ready_i;
  logic    cmp_valid_o;
  opcode_t cmp_op_o;
  age_t    cmp_age_o;
  preg_t   cmp_pdest_o;
  logic    cmp_pdest_valid_o;

  int seed         = 19;
  int ready_mode   = 0;
  int rnd_ready    = 0;
  int err_cnt      = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  logic cap_mode   = 1'b0;
  preg_t tag_ptr   = '1;

  // Reference model state, indexed by age or by tag
  opcode_t     exp_op     [32];
  preg_t       exp_pdest  [32];
  logic        exp_pdv    [32];
  int          dep0_ser   [32];
  int          dep1_ser   [32];
  int          ser_of_age [32];
  int          tag_prod   [64];
  bit          done_ser   [MAX_SER];
  logic [31:0] live;
  logic [63:0] tag_busy;
  age_t        age_cnt;
  int          live_cnt;
  int          ser_cnt = 0;
  logic        post_flush;

  logic    acc;
  logic    cmp_fire;
  logic    live_c;
  opcode_t exp_op_c;
  preg_t   exp_pdest_c;
  logic    exp_pdv_c;
  int      dep0_c;
  int      dep1_c;
  logic    dep_ok_c;

  ooo_issue_top dut0 (
    .clk, .rst_n, .flush_i,
    .disp_valid_i, .disp_op_i,
    .disp_psrc0_i, .disp_psrc0_valid_i,
    .disp_psrc1_i, .disp_psrc1_valid_i,
    .disp_pdest_i, .disp_pdest_valid_i,
    .disp_ready_o,
    .cmp_ready_i, .cmp_valid_o, .cmp_op_o, .cmp_age_o,
    .cmp_pdest_o, .cmp_pdest_valid_o
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Completion ready: held high, held low, or random per cycle
  always @(negedge clk) begin
    rnd_ready = $random(seed);
    case (ready_mode)
      0: cmp_ready_i = 1'b1;
      1: cmp_ready_i = 1'b0;
      default: cmp_ready_i = rnd_ready[0];
    endcase
  end

  // ========================================
  // Reference model
  // ========================================

  assign acc      = disp_valid_i && disp_ready_o;
  assign cmp_fire = cmp_valid_o && cmp_ready_i;

  always @(posedge clk) begin
    if (!rst_n || flush_i) begin
      live       <= '0;
      tag_busy   <= '0;
      age_cnt    <= '0;
      live_cnt   <= 0;
      post_flush <= rst_n && flush_i;
    end else begin
      if (cmp_fire) begin
        live[cmp_age_o] <= 1'b0;
        done_ser[ser_of_age[cmp_age_o]] <= 1'b1;
        if (cmp_pdest_valid_o) begin
          tag_busy[cmp_pdest_o] <= 1'b0;
        end
      end
      if (acc) begin
        exp_op[age_cnt]     <= disp_op_i;
        exp_pdest[age_cnt]  <= disp_pdest_i;
        exp_pdv[age_cnt]    <= disp_pdest_valid_i;
        live[age_cnt]       <= 1'b1;
        ser_of_age[age_cnt] <= ser_cnt;
        // Producer serial of each source still in flight
        dep0_ser[age_cnt] <= (disp_psrc0_valid_i && tag_busy[disp_psrc0_i]) ?
                             tag_prod[disp_psrc0_i] : -1;
        dep1_ser[age_cnt] <= (disp_psrc1_valid_i && tag_busy[disp_psrc1_i]) ?
                             tag_prod[disp_psrc1_i] : -1;
        if (disp_pdest_valid_i) begin
          tag_busy[disp_pdest_i] <= 1'b1;
          tag_prod[disp_pdest_i] <= ser_cnt;
        end
        ser_cnt    <= ser_cnt + 1;
        age_cnt    <= age_cnt + 1'b1;
        post_flush <= 1'b0;
      end
      live_cnt <= live_cnt + (acc ? 1 : 0) - (cmp_fire ? 1 : 0);
    end
  end

  always_comb begin
    live_c      = live[cmp_age_o];
    exp_op_c    = exp_op[cmp_age_o];
    exp_pdest_c = exp_pdest[cmp_age_o];
    exp_pdv_c   = exp_pdv[cmp_age_o];
    dep0_c      = dep0_ser[cmp_age_o];
    dep1_c      = dep1_ser[cmp_age_o];
    dep_ok_c    = 1'b1;
    if (dep0_c >= 0 && !done_ser[dep0_c]) begin
      dep_ok_c = 1'b0;
    end
    if (dep1_c >= 0 && !done_ser[dep1_c]) begin
      dep_ok_c = 1'b0;
    end
  end

  // ========================================
  // Checks
  // ========================================

  a_cmp_live: assert property (@(posedge clk) disable iff (!rst_n) cmp_fire |-> live_c)
    else begin
      err_cnt = err_cnt + 1;
      $display("ERR cmp_age_o %h has no outstanding op", $sampled(cmp_age_o));
    end

  a_cmp_op: assert property (@(posedge clk) disable iff (!rst_n)
    cmp_fire |-> cmp_op_o == exp_op_c)
    else begin
      err_cnt = err_cnt + 1;
      $display("ERR cmp_op_o got %h exp %h", $sampled(cmp_op_o), $sampled(exp_op_c));
    end

  a_cmp_pdest: assert property (@(posedge clk) disable iff (!rst_n)
    cmp_fire && exp_pdv_c |-> cmp_pdest_o == exp_pdest_c)
    else begin
      err_cnt = err_cnt + 1;
      $display("ERR cmp_pdest_o got %h exp %h", $sampled(cmp_pdest_o),
               $sampled(exp_pdest_c));
    end

  a_cmp_pdv: assert property (@(posedge clk) disable iff (!rst_n)
    cmp_fire |-> cmp_pdest_valid_o == exp_pdv_c)
    else begin
      err_cnt = err_cnt + 1;
      $display("ERR cmp_pdest_valid_o got %h exp %h", $sampled(cmp_pdest_valid_o),
               $sampled(exp_pdv_c));
    end

  // Consumer only after its producer's completion was taken
  a_dep_order: assert property (@(posedge clk) disable iff (!rst_n) cmp_fire |-> dep_ok_c)
    else begin
      err_cnt = err_cnt + 1;
      $display("Op with age %h completed before its producer", $sampled(cmp_age_o));
    end

  a_cmp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    cmp_valid_o && !cmp_ready_i && !flush_i |=>
      cmp_valid_o && $stable({cmp_op_o, cmp_age_o, cmp_pdest_o, cmp_pdest_valid_o}))
    else begin
      err_cnt = err_cnt + 1;
      $display("Completion outputs changed while cmp_ready_i was low");
    end

  a_cap: assert property (@(posedge clk) disable iff (!rst_n)
    cap_mode && $fell(disp_ready_o) |-> live_cnt == CAP)
    else begin
      err_cnt = err_cnt + 1;
      $display("ERR disp_ready_o fell with ops in flight %h exp %h", $sampled(live_cnt), CAP);
    end

  a_flush_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    post_flush |-> !cmp_valid_o)
    else begin
      err_cnt = err_cnt + 1;
      $display("Completion appeared after flush before any new dispatch");
    end

  a_idle_ready: assert property (@(posedge clk) disable iff (!rst_n)
    live_cnt == 0 |-> disp_ready_o)
    else begin
      err_cnt = err_cnt + 1;
      $display("disp_ready_o low with no ops outstanding");
    end

  // ========================================
  // Stimulus helpers
  // ========================================

  // Next free destination tag, round-robin
  function automatic preg_t alloc_tag();
    preg_t t;
    int n;
    n = 0;
    t = tag_ptr + 1'b1;
    while (tag_busy[t] && n < 64) begin
      t = t + 1'b1;
      n++;
    end
    tag_ptr = t;
    return t;
  endfunction

  task automatic drive_op(input opcode_t op, input preg_t s0, input logic s0v,
                          input preg_t s1, input logic s1v, input logic dv,
                          input preg_t d);
    disp_valid_i       = 1'b1;
    disp_op_i          = op;
    disp_psrc0_i       = s0;
    disp_psrc0_valid_i = s0v;
    disp_psrc1_i       = s1;
    disp_psrc1_valid_i = s1v;
    disp_pdest_i       = d;
    disp_pdest_valid_i = dv;
  endtask

  // Returns after the accepting edge
  task automatic dispatch_op(input opcode_t op, input preg_t s0, input logic s0v,
                             input preg_t s1, input logic s1v, input logic dv,
                             output preg_t d);
    int waited;
    logic rdy;
    d = alloc_tag();
    waited = 0;
    @(negedge clk);
    drive_op(op, s0, s0v, s1, s1v, dv, d);
    rdy = disp_ready_o;
    while (!rdy && waited < DISP_WAIT) begin
      @(negedge clk);
      rdy = disp_ready_o;
      waited++;
    end
    if (!rdy) begin
      err_cnt++;
      $display("Dispatch not accepted within %0d cycles", DISP_WAIT);
      disp_valid_i = 1'b0;
    end else begin
      @(posedge clk);
    end
  endtask

  task automatic end_dispatch();
    @(negedge clk);
    disp_valid_i = 1'b0;
  endtask

  task automatic set_ready_mode(input int m);
    @(posedge clk);
    ready_mode = m;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    end_dispatch();
    while (live_cnt != 0 && n < DRAIN_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (live_cnt != 0) begin
      err_cnt++;
      $display("%0d ops never completed", live_cnt);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("[PASS] %s", name);
    end else begin
      tests_failed++;
      $display("[FAIL] %s (%0d errors)", name, err_cnt - errs_before);
    end
  endtask

  // ========================================
  // Tests
  // ========================================

  task automatic run_independent();
    int e0;
    preg_t d;
    e0 = err_cnt;
    set_ready_mode(0);
    for (int i = 0; i < N_IND; i++) begin
      dispatch_op(opcode_t'(i), '0, 1'b0, '0, 1'b0, 1'b1, d);
    end
    wait_drain();
    report_test("independent ops", e0);
  endtask

  task automatic run_chain();
    int e0;
    preg_t prev;
    preg_t d;
    e0 = err_cnt;
    dispatch_op(4'h1, '0, 1'b0, '0, 1'b0, 1'b1, prev);
    for (int i = 1; i < N_CHAIN; i++) begin
      dispatch_op(opcode_t'(i), prev, 1'b1, prev, i[0], 1'b1, d);
      prev = d;
    end
    wait_drain();
    report_test("dependency chain", e0);
  endtask

  task automatic run_random();
    int e0;
    int r;
    int rec_ptr;
    preg_t recent [4];
    preg_t d;
    e0 = err_cnt;
    rec_ptr = 0;
    for (int i = 0; i < 4; i++) begin
      recent[i] = '0;
    end
    set_ready_mode(2);
    for (int i = 0; i < N_RAND; i++) begin
      r = $random(seed);
      dispatch_op(opcode_t'(r[11:8]), recent[r[1:0]], r[2], recent[r[4:3]], r[5],
                  r[7:6] != 2'b00, d);
      if (r[7:6] != 2'b00) begin
        recent[rec_ptr] = d;
        rec_ptr = (rec_ptr + 1) % 4;
      end
    end
    wait_drain();
    set_ready_mode(0);
    report_test("random dependence", e0);
  endtask

  task automatic run_backpressure();
    int e0;
    preg_t d;
    e0 = err_cnt;
    set_ready_mode(1);
    for (int i = 0; i < N_BP; i++) begin
      dispatch_op(opcode_t'(i + 3), '0, 1'b0, '0, 1'b0, 1'b1, d);
    end
    end_dispatch();
    repeat (8) @(negedge clk);
    set_ready_mode(2);
    wait_drain();
    set_ready_mode(0);
    report_test("completion back-pressure", e0);
  endtask

  task automatic run_capacity();
    int e0;
    int n;
    int waited;
    logic full;
    preg_t d;
    e0 = err_cnt;
    set_ready_mode(1);
    cap_mode = 1'b1;
    n = 0;
    full = 1'b0;
    while (!full && n < CAP + 4) begin
      @(negedge clk);
      if (!disp_ready_o) begin
        full = 1'b1;
        disp_valid_i = 1'b0;
      end else begin
        d = alloc_tag();
        drive_op(opcode_t'(n), '0, 1'b0, '0, 1'b0, 1'b1, d);
        @(posedge clk);
        n++;
      end
    end
    if (!full) begin
      err_cnt++;
      $display("disp_ready_o never fell with completion stalled");
    end
    end_dispatch();
    repeat (3) @(negedge clk);
    // Exactly one completion accepted
    set_ready_mode(0);
    set_ready_mode(1);
    waited = 0;
    @(negedge clk);
    while (!disp_ready_o && waited < 2 * EXEC_LAT + 4) begin
      @(negedge clk);
      waited++;
    end
    if (!disp_ready_o) begin
      err_cnt++;
      $display("disp_ready_o stayed low after a completion was accepted");
    end
    cap_mode = 1'b0;
    set_ready_mode(0);
    wait_drain();
    report_test("capacity", e0);
  endtask

  task automatic run_flush();
    int e0;
    preg_t old [N_FL];
    preg_t prev;
    preg_t d;
    e0 = err_cnt;
    prev = '0;
    set_ready_mode(1);
    for (int i = 0; i < N_FL; i++) begin
      dispatch_op(opcode_t'(i), prev, i > 0, '0, 1'b0, 1'b1, old[i]);
      prev = old[i];
    end
    end_dispatch();
    repeat (4) @(negedge clk);
    flush_i = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    set_ready_mode(0);
    repeat (10) @(negedge clk);
    // Reuse the flushed tags, so a leftover bank entry would wake and show up
    tag_ptr = old[0] - 1'b1;
    // Old producers are gone, so these sources must not wait
    for (int i = 0; i < N_FL; i++) begin
      dispatch_op(opcode_t'(i + 8), old[i], 1'b1, old[(i + 1) % N_FL], 1'b1, 1'b1, d);
    end
    wait_drain();
    report_test("flush", e0);
  endtask

  // ========================================
  // Main sequence and watchdog
  // ========================================

  initial begin
    rst_n              = 1'b0;
    flush_i            = 1'b0;
    disp_valid_i       = 1'b0;
    disp_op_i          = '0;
    disp_psrc0_i       = '0;
    disp_psrc0_valid_i = 1'b0;
    disp_psrc1_i       = '0;
    disp_psrc1_valid_i = 1'b0;
    disp_pdest_i       = '0;
    disp_pdest_valid_i = 1'b0;
    cmp_ready_i        = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    run_independent();
    run_chain();
    run_random();
    run_backpressure();
    run_capacity();
    run_flush();
    repeat (4) @(negedge clk);
    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: ooo_issue_top.f
issue_pkg.sv
dispatch_steer.sv
rs_bank.sv
exec_pipe.sv
ooo_issue_top.sv
tb_ooo_issue.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the issue stage simulation with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ooo_issue -f ooo_issue_top.f -o sim_ooo_issue

./obj_dir/sim_ooo_issue | tee sim.log

if grep -q "All tests passed!" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
